// File: Bender.yml
package:
  name: mbtrain_controller

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mbtrain_pkg.sv
      - verilog/mbtrain_step_decoder.sv
      - verilog/mbtrain_sequencer.sv
      - verilog/mbtrain_speed_tracker.sv
      - verilog/mbtrain_lane_tracker.sv
      - verilog/mbtrain_controller.sv
  - target: test
    files:
      - testbench/tb_mbtrain_controller.sv

// File: src.f
+incdir+verilog
verilog/mbtrain_pkg.sv
verilog/mbtrain_step_decoder.sv
verilog/mbtrain_sequencer.sv
verilog/mbtrain_speed_tracker.sv
verilog/mbtrain_lane_tracker.sv
verilog/mbtrain_controller.sv
testbench/tb_mbtrain_controller.sv

// File: testbench/tb_mbtrain_controller.sv
`timescale 1ns/1ps

module tb_mbtrain_controller
	import mbtrain_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DELAY = 5;
	// twice 7 scenarios of 30 substeps at 10 cycles each plus slack
	localparam int TIMEOUT_CYCLES = 2 * 7 * 30 * 10 + 800;

	// expected handshake position of the substep engine
	typedef enum logic [1:0] {
		W_IDLE,
		W_ENABLED,
		W_RELEASE,
		W_DONE
	} watch_e;

	logic           clk;
	logic           rst_n;
	logic           i_en;
	retrain_entry_e i_phyretrain_resolved_state;
	speed_t         i_highest_common_speed;
	lane_halves_t   i_tx_lanes_mbinit;
	lane_halves_t   i_rx_lanes_mbinit;
	lane_halves_t   i_tx_lanes_linkspeed;
	lane_halves_t   i_rx_lanes_repair;
	logic           i_phy_retrain_req;
	logic           i_error_req;
	logic           i_speed_degrade_req;
	logic           i_repair_req;
	step_vec_t      i_step_ack;
	step_vec_t      o_step_en;
	logic [3:0]     o_sideband_substate;
	pattern_mux_e   o_mux_sel;
	logic           o_mainband_or_valtrain_test;
	logic           o_phyretrain_en;
	logic           o_mbtrain_ack;
	lane_halves_t   o_tx_lanes;
	lane_halves_t   o_rx_lanes;
	logic           o_coming_from_repair;
	speed_t         o_current_operating_speed;

	watch_e       w_state;
	train_step_e  w_step;
	logic         w_retrain;
	speed_t       w_speed;
	lane_halves_t w_tx;
	lane_halves_t w_rx;
	logic         w_repair;
	logic         err_req;
	step_vec_t    exp_en;
	logic [3:0]   exp_substate;
	pattern_mux_e exp_mux;
	logic         exp_val_test;
	integer       seed;
	int           cycle_count;

	mbtrain_controller dut0 (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic train_step_e first_step_of(input retrain_entry_e entry);
		case (entry)
			ENTRY_TX_SELF_CAL:   first_step_of = STEP_TX_SELF_CAL;
			ENTRY_REPAIR:        first_step_of = STEP_REPAIR;
			ENTRY_SPEED_DEGRADE: first_step_of = STEP_SPEED_IDLE;
			default:             first_step_of = STEP_VALVREF;
		endcase
	endfunction

	// training order where repair resumes at tx self cal
	function automatic train_step_e step_after(input train_step_e step);
		if (step == STEP_REPAIR)
			step_after = STEP_TX_SELF_CAL;
		else
			step_after = train_step_e'(step + 4'd1);
	endfunction

	function automatic pattern_mux_e pattern_for(input train_step_e step);
		case (step)
			STEP_SPEED_IDLE, STEP_TX_SELF_CAL: pattern_for = MUX_SELF_CAL;
			STEP_VAL_TRAIN_CENTER, STEP_DATA_TRAIN_CENTER1,
			STEP_DATA_TRAIN_CENTER2:          pattern_for = MUX_CENTER;
			STEP_RX_CLK_CAL, STEP_RX_DESKEW:  pattern_for = MUX_RX_CAL;
			STEP_LINK_SPEED:                  pattern_for = MUX_LINK_SPEED;
			STEP_REPAIR:                      pattern_for = MUX_REPAIR;
			default:                          pattern_for = MUX_VREF;
		endcase
	endfunction

	function automatic logic is_valid_lane_step(input train_step_e step);
		is_valid_lane_step = (step == STEP_VALVREF) || (step == STEP_VAL_TRAIN_CENTER) ||
		                     (step == STEP_VAL_TRAIN_VREF);
	endfunction

	function automatic speed_t speed_down(input speed_t speed);
		speed_down = (speed == '0) ? speed : speed_t'(speed - 3'd1);
	endfunction

	task automatic stop_failing(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string name, input logic [15:0] got,
	                               input logic [15:0] exp);
		stop_failing($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	task automatic set_link_inputs(input speed_t hcs, input lane_halves_t tx_mbinit,
	                               input lane_halves_t rx_mbinit, input lane_halves_t tx_ls,
	                               input lane_halves_t rx_rep);
		i_highest_common_speed = hcs;
		i_tx_lanes_mbinit      = tx_mbinit;
		i_rx_lanes_mbinit      = rx_mbinit;
		i_tx_lanes_linkspeed   = tx_ls;
		i_rx_lanes_repair      = rx_rep;
	endtask

	// request flags only apply to the first link speed outcome
	task automatic run_training(input retrain_entry_e entry, input logic retrain,
	                            input logic error_req, input logic degrade, input logic repair);
		i_phyretrain_resolved_state = entry;
		i_phy_retrain_req   = retrain;
		i_error_req         = error_req;
		i_speed_degrade_req = degrade;
		i_repair_req        = repair;
		i_en                = 1'b1;
		while (!o_step_en[STEP_LINK_SPEED]) @(posedge clk);
		while (!(o_mbtrain_ack || (o_step_en != '0 && !o_step_en[STEP_LINK_SPEED])))
			@(posedge clk);
		#DRIVE_DELAY;
		i_phy_retrain_req   = 1'b0;
		i_error_req         = 1'b0;
		i_speed_degrade_req = 1'b0;
		i_repair_req        = 1'b0;
		while (!o_mbtrain_ack) @(posedge clk);
		repeat (2) @(posedge clk);
		#DRIVE_DELAY;
		i_en = 1'b0;
		@(posedge clk);
		while (o_mbtrain_ack) @(posedge clk);
		#DRIVE_DELAY;
	endtask

	// substep engine with random ack latency on both edges of the handshake
	always begin : responder
		step_vec_t held;
		int        wait_cycles;
		@(posedge clk);
		if (rst_n && o_step_en != '0) begin
			held = o_step_en;
			wait_cycles = {$random(seed)} % 4;
			repeat (wait_cycles) @(posedge clk);
			#DRIVE_DELAY;
			i_step_ack = held;
			@(posedge clk);
			while (o_step_en != '0) @(posedge clk);
			wait_cycles = {$random(seed)} % 4;
			repeat (wait_cycles) @(posedge clk);
			#DRIVE_DELAY;
			i_step_ack = '0;
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			stop_failing("timeout, training did not finish within the cycle limit");
	end

	assign err_req = i_error_req || i_repair_req;

	// reference model advancing one state per handshake transition
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			w_state   <= W_IDLE;
			w_step    <= STEP_VALVREF;
			w_retrain <= 1'b0;
			w_speed   <= '0;
			w_tx      <= '0;
			w_rx      <= '0;
			w_repair  <= 1'b0;
		end else begin
			case (w_state)
				W_IDLE: begin
					if (i_en) begin
						w_state   <= W_ENABLED;
						w_step    <= first_step_of(i_phyretrain_resolved_state);
						w_retrain <= 1'b0;
						case (i_phyretrain_resolved_state)
							ENTRY_FULL: begin
								w_speed <= i_highest_common_speed;
								w_tx    <= i_tx_lanes_mbinit;
								w_rx    <= i_rx_lanes_mbinit;
								if (i_tx_lanes_mbinit != 2'b11)
									w_repair <= 1'b1;
							end
							ENTRY_REPAIR:        w_repair <= 1'b1;
							ENTRY_SPEED_DEGRADE: w_speed <= speed_down(w_speed);
							default:             ;
						endcase
					end
				end
				W_ENABLED: begin
					if (i_step_ack[w_step])
						w_state <= W_RELEASE;
				end
				W_RELEASE: begin
					if (!i_step_ack[w_step]) begin
						if (w_step == STEP_REPAIR)
							w_rx <= i_rx_lanes_repair;
						if (w_step != STEP_LINK_SPEED) begin
							w_state <= W_ENABLED;
							w_step  <= step_after(w_step);
						end else begin
							if (i_tx_lanes_linkspeed != '0)
								w_tx <= i_tx_lanes_linkspeed;
							if (i_phy_retrain_req) begin
								w_state   <= W_DONE;
								w_retrain <= 1'b1;
							end else if (err_req && i_speed_degrade_req) begin
								w_state <= W_ENABLED;
								w_step  <= STEP_SPEED_IDLE;
								w_speed <= speed_down(w_speed);
							end else if (err_req) begin
								w_state  <= W_ENABLED;
								w_step   <= STEP_REPAIR;
								w_repair <= 1'b1;
							end else begin
								w_state <= W_DONE;
							end
						end
					end
				end
				default: begin
					if (!i_en) begin
						w_state   <= W_IDLE;
						w_retrain <= 1'b0;
						w_repair  <= 1'b0;
					end
				end
			endcase
		end
	end

	assign exp_en       = (w_state == W_ENABLED) ? (step_vec_t'(1) << w_step) : '0;
	assign exp_substate = (w_state == W_IDLE || w_state == W_DONE) ? 4'd0 : w_step;
	assign exp_mux      = pattern_for(w_step);
	assign exp_val_test = is_valid_lane_step(w_step);

	a_one_enable: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(o_step_en))
		else stop_failing("more than one substep enable is high at once");
	a_step_en: assert property (@(posedge clk) disable iff (!rst_n) o_step_en == exp_en)
		else report_mismatch("o_step_en", $sampled(o_step_en), $sampled(exp_en));
	a_substate: assert property (@(posedge clk) disable iff (!rst_n)
		o_sideband_substate == exp_substate)
		else report_mismatch("o_sideband_substate", $sampled(o_sideband_substate),
		                     $sampled(exp_substate));
	a_mux: assert property (@(posedge clk) disable iff (!rst_n)
		(o_step_en != '0) |-> (o_mux_sel == exp_mux))
		else report_mismatch("o_mux_sel", $sampled(o_mux_sel), $sampled(exp_mux));
	a_test_sel: assert property (@(posedge clk) disable iff (!rst_n)
		(o_step_en != '0) |-> (o_mainband_or_valtrain_test == exp_val_test))
		else report_mismatch("o_mainband_or_valtrain_test",
		                     $sampled(o_mainband_or_valtrain_test), $sampled(exp_val_test));
	a_ack: assert property (@(posedge clk) disable iff (!rst_n)
		o_mbtrain_ack == (w_state == W_DONE))
		else report_mismatch("o_mbtrain_ack", $sampled(o_mbtrain_ack),
		                     $sampled(w_state == W_DONE));
	a_retrain: assert property (@(posedge clk) disable iff (!rst_n)
		o_phyretrain_en == (w_state == W_DONE && w_retrain))
		else report_mismatch("o_phyretrain_en", $sampled(o_phyretrain_en),
		                     $sampled(w_state == W_DONE && w_retrain));
	a_speed: assert property (@(posedge clk) disable iff (!rst_n)
		o_current_operating_speed == w_speed)
		else report_mismatch("o_current_operating_speed",
		                     $sampled(o_current_operating_speed), $sampled(w_speed));
	a_tx_lanes: assert property (@(posedge clk) disable iff (!rst_n) o_tx_lanes == w_tx)
		else report_mismatch("o_tx_lanes", $sampled(o_tx_lanes), $sampled(w_tx));
	a_rx_lanes: assert property (@(posedge clk) disable iff (!rst_n) o_rx_lanes == w_rx)
		else report_mismatch("o_rx_lanes", $sampled(o_rx_lanes), $sampled(w_rx));
	a_repair_flag: assert property (@(posedge clk) disable iff (!rst_n)
		o_coming_from_repair == w_repair)
		else report_mismatch("o_coming_from_repair", $sampled(o_coming_from_repair),
		                     $sampled(w_repair));

	initial begin
		seed        = 42;
		cycle_count = 0;
		clk         = 1'b0;
		rst_n       = 1'b0;
		i_en        = 1'b0;
		i_step_ack  = '0;
		i_phyretrain_resolved_state = ENTRY_FULL;
		i_phy_retrain_req   = 1'b0;
		i_error_req         = 1'b0;
		i_speed_degrade_req = 1'b0;
		i_repair_req        = 1'b0;
		set_link_inputs(3'd0, 2'b00, 2'b00, 2'b00, 2'b00);
		repeat (3) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		@(posedge clk);
		#DRIVE_DELAY;

		// full start on all sixteen lanes with a clean finish
		set_link_inputs(3'd4, 2'b11, 2'b11, 2'b11, 2'b11);
		run_training(ENTRY_FULL, 1'b0, 1'b0, 1'b0, 1'b0);
		// mbinit gives the lower half only, then one degrade and a zero link speed mask
		set_link_inputs(3'd1, 2'b01, 2'b11, 2'b00, 2'b11);
		run_training(ENTRY_FULL, 1'b0, 1'b1, 1'b1, 1'b0);
		// repair request where the partner keeps the upper half
		set_link_inputs(3'd3, 2'b11, 2'b11, 2'b10, 2'b10);
		run_training(ENTRY_FULL, 1'b0, 1'b0, 1'b0, 1'b1);
		// retrain wins over a pending error
		set_link_inputs(3'd1, 2'b11, 2'b11, 2'b11, 2'b11);
		run_training(ENTRY_FULL, 1'b1, 1'b1, 1'b0, 1'b0);
		set_link_inputs(3'd6, 2'b11, 2'b11, 2'b01, 2'b11);
		run_training(ENTRY_TX_SELF_CAL, 1'b0, 1'b0, 1'b0, 1'b0);
		set_link_inputs(3'd6, 2'b11, 2'b11, 2'b11, 2'b01);
		run_training(ENTRY_REPAIR, 1'b0, 1'b0, 1'b0, 1'b0);
		// speed goes 1 to 0 on entry, then stays at 0 on the second degrade
		run_training(ENTRY_SPEED_DEGRADE, 1'b0, 1'b1, 1'b1, 1'b0);

		$display("Test OK");
		$finish;
	end

endmodule

// File: verilog/mbtrain_controller.sv
`timescale 1ns/1ps
`include "mbtrain_defines.svh"

module mbtrain_controller
	import mbtrain_pkg::*;
(
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       i_en,
	input  retrain_entry_e             i_phyretrain_resolved_state,
	input  speed_t                     i_highest_common_speed,
	input  lane_halves_t               i_tx_lanes_mbinit,
	input  lane_halves_t               i_rx_lanes_mbinit,
	input  lane_halves_t               i_tx_lanes_linkspeed,
	input  lane_halves_t               i_rx_lanes_repair,
	input  logic                       i_phy_retrain_req,
	input  logic                       i_error_req,
	input  logic                       i_speed_degrade_req,
	input  logic                       i_repair_req,
	input  step_vec_t                  i_step_ack,
	output step_vec_t                  o_step_en,
	output logic [`MBT_SUBSTATE_W-1:0] o_sideband_substate,
	output pattern_mux_e               o_mux_sel,
	output logic                       o_mainband_or_valtrain_test,
	output logic                       o_phyretrain_en,
	output logic                       o_mbtrain_ack,
	output lane_halves_t               o_tx_lanes,
	output lane_halves_t               o_rx_lanes,
	output logic                       o_coming_from_repair,
	output speed_t                     o_current_operating_speed
);

	train_step_e step;
	logic        running;
	logic        error_or_repair;
	logic        full_start;
	logic        degrade;
	logic        linkspeed_done;
	logic        repair_enter;
	logic        repair_done;
	logic        back_to_idle;

	// a repair request lands on the error path, degrade decides between the two
	assign error_or_repair = i_error_req || i_repair_req;

	mbtrain_sequencer u_sequencer (
		.clk                 (clk),
		.rst_n               (rst_n),
		.i_en                (i_en),
		.i_entry             (i_phyretrain_resolved_state),
		.i_step_ack          (i_step_ack),
		.i_phy_retrain_req   (i_phy_retrain_req),
		.i_error_req         (error_or_repair),
		.i_speed_degrade_req (i_speed_degrade_req),
		.o_step              (step),
		.o_running           (running),
		.o_finish            (o_mbtrain_ack),
		.o_phyretrain_en     (o_phyretrain_en),
		.o_full_start        (full_start),
		.o_degrade           (degrade),
		.o_linkspeed_done    (linkspeed_done),
		.o_repair_enter      (repair_enter),
		.o_repair_done       (repair_done),
		.o_back_to_idle      (back_to_idle)
	);

	mbtrain_step_decoder u_step_decoder (
		.i_step                      (step),
		.i_running                   (running),
		.o_step_en                   (o_step_en),
		.o_sideband_substate         (o_sideband_substate),
		.o_mux_sel                   (o_mux_sel),
		.o_mainband_or_valtrain_test (o_mainband_or_valtrain_test)
	);

	mbtrain_speed_tracker u_speed_tracker (
		.clk                    (clk),
		.rst_n                  (rst_n),
		.i_full_start           (full_start),
		.i_degrade              (degrade),
		.i_highest_common_speed (i_highest_common_speed),
		.o_speed                (o_current_operating_speed)
	);

	mbtrain_lane_tracker u_lane_tracker (
		.clk                  (clk),
		.rst_n                (rst_n),
		.i_full_start         (full_start),
		.i_linkspeed_done     (linkspeed_done),
		.i_repair_enter       (repair_enter),
		.i_repair_done        (repair_done),
		.i_back_to_idle       (back_to_idle),
		.i_tx_mbinit          (i_tx_lanes_mbinit),
		.i_rx_mbinit          (i_rx_lanes_mbinit),
		.i_tx_linkspeed       (i_tx_lanes_linkspeed),
		.i_rx_repair          (i_rx_lanes_repair),
		.o_tx_lanes           (o_tx_lanes),
		.o_rx_lanes           (o_rx_lanes),
		.o_coming_from_repair (o_coming_from_repair)
	);

endmodule

// File: verilog/mbtrain_defines.svh
`ifndef MBTRAIN_DEFINES_SVH
`define MBTRAIN_DEFINES_SVH

// number of training substeps including repair
`define MBT_NUM_STEPS 13

// speed code width, highest common speed comes from mbinit
`define MBT_SPEED_W 3

// sideband substate code width
`define MBT_SUBSTATE_W 4

// pattern generator/detector mux select width
`define MBT_MUX_W 3

// lanes are tracked in halves of eight
`define MBT_LANE_HALVES 2

`endif

// File: verilog/mbtrain_lane_tracker.sv
`timescale 1ns/1ps

module mbtrain_lane_tracker
	import mbtrain_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         i_full_start,
	input  logic         i_linkspeed_done,
	input  logic         i_repair_enter,
	input  logic         i_repair_done,
	input  logic         i_back_to_idle,
	input  lane_halves_t i_tx_mbinit,
	input  lane_halves_t i_rx_mbinit,
	input  lane_halves_t i_tx_linkspeed,
	input  lane_halves_t i_rx_repair,
	output lane_halves_t o_tx_lanes,
	output lane_halves_t o_rx_lanes,
	output logic         o_coming_from_repair
);

	lane_halves_t tx_q;
	lane_halves_t rx_q;
	logic         repair_q;

	// tx width is settled by the link speed point test
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_q <= '0;
		end else if (i_full_start) begin
			tx_q <= i_tx_mbinit;
		end else if (i_linkspeed_done && (i_tx_linkspeed != '0)) begin
			tx_q <= i_tx_linkspeed;
		end
	end

	// rx width follows what repair agreed with the partner
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_q <= '0;
		end else if (i_full_start) begin
			rx_q <= i_rx_mbinit;
		end else if (i_repair_done) begin
			rx_q <= i_rx_repair;
		end
	end

	// mbinit already running on half the lanes counts as a repair too
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			repair_q <= 1'b0;
		end else if (i_back_to_idle) begin
			repair_q <= 1'b0;
		end else if (i_full_start && (i_tx_mbinit != '1)) begin
			repair_q <= 1'b1;
		end else if (i_repair_enter) begin
			repair_q <= 1'b1;
		end
	end

	assign o_tx_lanes           = tx_q;
	assign o_rx_lanes           = rx_q;
	assign o_coming_from_repair = repair_q;

endmodule

// File: verilog/mbtrain_pkg.sv
`include "mbtrain_defines.svh"

package mbtrain_pkg;

	// step codes double as the sideband substate codes
	typedef enum logic [`MBT_SUBSTATE_W-1:0] {
		STEP_VALVREF            = 4'd0,
		STEP_DATAVREF           = 4'd1,
		STEP_SPEED_IDLE         = 4'd2,
		STEP_TX_SELF_CAL        = 4'd3,
		STEP_RX_CLK_CAL         = 4'd4,
		STEP_VAL_TRAIN_CENTER   = 4'd5,
		STEP_VAL_TRAIN_VREF     = 4'd6,
		STEP_DATA_TRAIN_CENTER1 = 4'd7,
		STEP_DATA_TRAIN_VREF    = 4'd8,
		STEP_RX_DESKEW          = 4'd9,
		STEP_DATA_TRAIN_CENTER2 = 4'd10,
		STEP_LINK_SPEED         = 4'd11,
		STEP_REPAIR             = 4'd12
	} train_step_e;

	// one bit per substep, indexed by train_step_e
	typedef logic [`MBT_NUM_STEPS-1:0] step_vec_t;

	typedef logic [`MBT_SPEED_W-1:0] speed_t;

	// bit 0 first eight lanes, bit 1 second eight lanes
	typedef logic [`MBT_LANE_HALVES-1:0] lane_halves_t;

	typedef enum logic [`MBT_MUX_W-1:0] {
		MUX_VREF       = 3'd0,
		MUX_SELF_CAL   = 3'd1,
		MUX_LINK_SPEED = 3'd2,
		MUX_REPAIR     = 3'd3,
		MUX_CENTER     = 3'd4,
		MUX_RX_CAL     = 3'd5
	} pattern_mux_e;

	// entry point chosen by a resolved phy retrain
	typedef enum logic [1:0] {
		ENTRY_FULL          = 2'd0,
		ENTRY_TX_SELF_CAL   = 2'd1,
		ENTRY_REPAIR        = 2'd2,
		ENTRY_SPEED_DEGRADE = 2'd3
	} retrain_entry_e;

endpackage

// File: verilog/mbtrain_sequencer.sv
`timescale 1ns/1ps

module mbtrain_sequencer
	import mbtrain_pkg::*;
(
	input  logic           clk,
	input  logic           rst_n,
	input  logic           i_en,
	input  retrain_entry_e i_entry,
	input  step_vec_t      i_step_ack,
	input  logic           i_phy_retrain_req,
	input  logic           i_error_req,
	input  logic           i_speed_degrade_req,
	output train_step_e    o_step,
	output logic           o_running,
	output logic           o_finish,
	output logic           o_phyretrain_en,
	output logic           o_full_start,
	output logic           o_degrade,
	output logic           o_linkspeed_done,
	output logic           o_repair_enter,
	output logic           o_repair_done,
	output logic           o_back_to_idle
);

	// run holds the enable high, end waits for the ack to drop
	typedef enum logic [1:0] {
		PH_IDLE,
		PH_RUN,
		PH_END,
		PH_FINISH
	} phase_e;

	phase_e      phase_q;
	train_step_e step_q;
	logic        phyretrain_q;

	logic start;
	logic step_ack;
	logic step_done;
	logic ls_degrade;
	logic ls_repair;

	// fixed training order, repair resumes at tx self cal
	function automatic train_step_e next_step(input train_step_e step);
		case (step)
			STEP_VALVREF:            next_step = STEP_DATAVREF;
			STEP_DATAVREF:           next_step = STEP_SPEED_IDLE;
			STEP_SPEED_IDLE:         next_step = STEP_TX_SELF_CAL;
			STEP_TX_SELF_CAL:        next_step = STEP_RX_CLK_CAL;
			STEP_RX_CLK_CAL:         next_step = STEP_VAL_TRAIN_CENTER;
			STEP_VAL_TRAIN_CENTER:   next_step = STEP_VAL_TRAIN_VREF;
			STEP_VAL_TRAIN_VREF:     next_step = STEP_DATA_TRAIN_CENTER1;
			STEP_DATA_TRAIN_CENTER1: next_step = STEP_DATA_TRAIN_VREF;
			STEP_DATA_TRAIN_VREF:    next_step = STEP_RX_DESKEW;
			STEP_RX_DESKEW:          next_step = STEP_DATA_TRAIN_CENTER2;
			STEP_DATA_TRAIN_CENTER2: next_step = STEP_LINK_SPEED;
			STEP_REPAIR:             next_step = STEP_TX_SELF_CAL;
			default:                 next_step = STEP_VALVREF;
		endcase
	endfunction

	function automatic train_step_e entry_step(input retrain_entry_e entry);
		case (entry)
			ENTRY_TX_SELF_CAL:   entry_step = STEP_TX_SELF_CAL;
			ENTRY_REPAIR:        entry_step = STEP_REPAIR;
			ENTRY_SPEED_DEGRADE: entry_step = STEP_SPEED_IDLE;
			default:             entry_step = STEP_VALVREF;
		endcase
	endfunction

	assign start     = (phase_q == PH_IDLE) && i_en;
	assign step_ack  = i_step_ack[step_q];
	assign step_done = (phase_q == PH_END) && !step_ack;

	// link speed outcome, retrain wins over any error
	assign ls_degrade = !i_phy_retrain_req && i_error_req && i_speed_degrade_req;
	assign ls_repair  = !i_phy_retrain_req && i_error_req && !i_speed_degrade_req;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase_q      <= PH_IDLE;
			step_q       <= STEP_VALVREF;
			phyretrain_q <= 1'b0;
		end else begin
			case (phase_q)
				PH_IDLE: begin
					if (i_en) begin
						phase_q      <= PH_RUN;
						step_q       <= entry_step(i_entry);
						phyretrain_q <= 1'b0;
					end
				end
				PH_RUN: begin
					if (step_ack) begin
						phase_q <= PH_END;
					end
				end
				PH_END: begin
					if (!step_ack) begin
						if (step_q != STEP_LINK_SPEED) begin
							phase_q <= PH_RUN;
							step_q  <= next_step(step_q);
						end else if (ls_degrade) begin
							phase_q <= PH_RUN;
							step_q  <= STEP_SPEED_IDLE;
						end else if (ls_repair) begin
							phase_q <= PH_RUN;
							step_q  <= STEP_REPAIR;
						end else begin
							// step back to code 0 so the sideband sees no substate
							phase_q      <= PH_FINISH;
							step_q       <= STEP_VALVREF;
							phyretrain_q <= i_phy_retrain_req;
						end
					end
				end
				PH_FINISH: begin
					if (!i_en) begin
						phase_q      <= PH_IDLE;
						phyretrain_q <= 1'b0;
					end
				end
				default: phase_q <= PH_IDLE;
			endcase
		end
	end

	assign o_step          = step_q;
	assign o_running       = (phase_q == PH_RUN);
	assign o_finish        = (phase_q == PH_FINISH);
	assign o_phyretrain_en = phyretrain_q;

	// event pulses for the trackers, high for the transition cycle only
	assign o_full_start     = start && (i_entry == ENTRY_FULL);
	assign o_linkspeed_done = step_done && (step_q == STEP_LINK_SPEED);
	assign o_repair_done    = step_done && (step_q == STEP_REPAIR);
	assign o_degrade        = (start && (i_entry == ENTRY_SPEED_DEGRADE)) ||
	                          (o_linkspeed_done && ls_degrade);
	assign o_repair_enter   = (start && (i_entry == ENTRY_REPAIR)) ||
	                          (o_linkspeed_done && ls_repair);
	assign o_back_to_idle   = (phase_q == PH_FINISH) && !i_en;

endmodule

// File: verilog/mbtrain_speed_tracker.sv
`timescale 1ns/1ps

module mbtrain_speed_tracker
	import mbtrain_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   i_full_start,
	input  logic   i_degrade,
	input  speed_t i_highest_common_speed,
	output speed_t o_speed
);

	speed_t speed_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			speed_q <= '0;
		end else if (i_full_start) begin
			speed_q <= i_highest_common_speed;
		end else if (i_degrade && (speed_q != '0)) begin
			// lowest speed code is the floor
			speed_q <= speed_q - speed_t'(1);
		end
	end

	assign o_speed = speed_q;

endmodule

// File: verilog/mbtrain_step_decoder.sv
`timescale 1ns/1ps
`include "mbtrain_defines.svh"

module mbtrain_step_decoder
	import mbtrain_pkg::*;
(
	input  train_step_e                i_step,
	input  logic                       i_running,
	output step_vec_t                  o_step_en,
	output logic [`MBT_SUBSTATE_W-1:0] o_sideband_substate,
	output pattern_mux_e               o_mux_sel,
	output logic                       o_mainband_or_valtrain_test
);

	logic val_step;

	// one hot enable of the active substep
	assign o_step_en = i_running ? (step_vec_t'(1) << i_step) : '0;

	// sequencer parks the step at code 0 outside of training
	assign o_sideband_substate = i_step;

	always_comb begin
		case (i_step)
			STEP_VALVREF,
			STEP_DATAVREF,
			STEP_VAL_TRAIN_VREF,
			STEP_DATA_TRAIN_VREF:    o_mux_sel = MUX_VREF;
			STEP_SPEED_IDLE,
			STEP_TX_SELF_CAL:        o_mux_sel = MUX_SELF_CAL;
			STEP_VAL_TRAIN_CENTER,
			STEP_DATA_TRAIN_CENTER1,
			STEP_DATA_TRAIN_CENTER2: o_mux_sel = MUX_CENTER;
			STEP_RX_CLK_CAL,
			STEP_RX_DESKEW:          o_mux_sel = MUX_RX_CAL;
			STEP_LINK_SPEED:         o_mux_sel = MUX_LINK_SPEED;
			STEP_REPAIR:             o_mux_sel = MUX_REPAIR;
			default:                 o_mux_sel = MUX_VREF;
		endcase
	end

	// valid lane steps test the valid lane, everything else the mainband
	always_comb begin
		case (i_step)
			STEP_VALVREF,
			STEP_VAL_TRAIN_CENTER,
			STEP_VAL_TRAIN_VREF: val_step = 1'b1;
			default:             val_step = 1'b0;
		endcase
	end

	assign o_mainband_or_valtrain_test = i_running && val_step;

endmodule
